//--- design/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    typedef enum logic [3:0] {
        op_li,
        op_ld_b,
        op_ld_bu,
        op_ld_h,
        op_ld_hu,
        op_ld_w,
        op_st_b,
        op_st_h,
        op_st_w
    } lsu_op_e;

    typedef enum logic [7:0] {
        ec_none = 8'h00,
        ec_ale  = 8'h09  // Address not aligned
    } ecode_e;

    typedef struct packed {
        lsu_op_e     op;
        logic [4:0]  rj;   // Base register
        logic [4:0]  rd;   // Destination, or store data source
        logic [15:0] imm;
        logic [31:0] pc;
    } issue_t;

    typedef struct packed {
        logic [31:0] pc;
        lsu_op_e     op;
        logic        gr_we;
        logic [4:0]  dest;
        logic [31:0] vaddr;
        logic [31:0] rf_wdata; // Immediate for load-immediate
        logic        ex;
        ecode_e      ecode;
    } em_t;

    typedef struct packed {
        logic [31:0] pc;
        logic        gr_we;
        logic [4:0]  dest;
        logic [31:0] wdata;
        logic [31:0] vaddr;
        logic        ex;
        ecode_e      ecode;
    } mw_t;

    typedef struct packed {
        logic [4:0]  valid_dest; // Zero when nothing is written
        logic [31:0] data;
        logic        data_ok;
        logic        ex;
    } fwd_t;

    typedef struct packed {
        logic [31:0] pc;
        logic        gr_we;
        logic [4:0]  dest;
        logic [31:0] wdata;
        logic        ex;
        ecode_e      ecode;
    } retire_t;

    function automatic logic is_load(input lsu_op_e op);
        return op inside {op_ld_b, op_ld_bu, op_ld_h, op_ld_hu, op_ld_w};
    endfunction

    function automatic logic is_store(input lsu_op_e op);
        return op inside {op_st_b, op_st_h, op_st_w};
    endfunction

endpackage

`default_nettype wire

//--- design/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire        clk,
    input  wire [4:0]  raddr1,
    input  wire [4:0]  raddr2,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2,
    input  wire        we,
    input  wire [4:0]  waddr,
    input  wire [31:0] wdata
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // Write-through so a same-cycle write is seen by the reader
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 :
                    (we && waddr == raddr1) ? wdata : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 :
                    (we && waddr == raddr2) ? wdata : regs[raddr2];

endmodule

`default_nettype wire

//--- design/data_sram.sv
`timescale 1ns/1ps
`default_nettype none

module data_sram #(
    parameter int DATA_LATENCY = 2,
    parameter int ADDR_WORDS   = 256
) (
    input  wire        clk,
    input  wire        rstn,
    input  wire        req,
    input  wire        wr,
    input  wire [3:0]  wstrb,
    input  wire [31:0] addr,
    input  wire [31:0] wdata,
    output logic       addr_ok,
    output logic       data_ok,
    output logic [31:0] rdata
);

    localparam int IDX_W = $clog2(ADDR_WORDS);
    localparam int CNT_W = $clog2(DATA_LATENCY + 1);

    logic [31:0]      mem [ADDR_WORDS];
    logic [CNT_W-1:0] cnt;
    logic [IDX_W-1:0] idx;
    logic [IDX_W-1:0] rd_idx;
    logic             accept;

    assign idx     = addr[IDX_W+1:2]; // Byte address to word index
    assign addr_ok = (cnt <= CNT_W'(1));
    assign accept  = req && addr_ok;
    assign data_ok = (cnt == CNT_W'(1));
    assign rdata   = data_ok ? mem[rd_idx] : 32'd0;

    // Read latency countdown
    always_ff @(posedge clk) begin
        if (!rstn) begin
            cnt <= '0;
        end else if (accept && !wr) begin
            cnt <= CNT_W'(DATA_LATENCY);
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !wr) begin
            rd_idx <= idx;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < ADDR_WORDS; i++) begin
                mem[i] <= 32'd0;
            end
        end else if (accept && wr) begin
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b]) begin
                    mem[idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- design/ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
    input  wire                  clk,
    input  wire                  rstn,
    input  wire                  flush,
    input  wire                  issue_valid,
    output logic                 issue_ready,
    input  wire lsu_pkg::issue_t issue,
    output logic [4:0]           rf_raddr1,
    output logic [4:0]           rf_raddr2,
    input  wire [31:0]           rf_rdata1,
    input  wire [31:0]           rf_rdata2,
    input  wire lsu_pkg::fwd_t   m_fwd,
    input  wire lsu_pkg::fwd_t   w_fwd,
    input  wire                  m_allowin,
    output logic                 em_valid,
    output lsu_pkg::em_t         em,
    output logic                 data_req,
    output logic                 data_wr,
    output logic [3:0]           data_wstrb,
    output logic [31:0]          data_addr,
    output logic [31:0]          data_wdata,
    input  wire                  data_addr_ok
);
    import lsu_pkg::*;

    logic        e_valid;
    issue_t      e_op;
    logic        e_allowin;
    logic        e_ready_go;
    logic [31:0] src1;
    logic [31:0] src2;
    logic [31:0] imm_ext;
    logic [31:0] vaddr;
    logic        misalign;
    logic        is_mem;
    logic        need_req;
    logic        raw_stall;
    logic        exc_stall;

    // Memory stage result wins over the write-through register file
    function automatic logic [31:0] pick(input logic [4:0] r, input logic [31:0] rf_val,
                                         input fwd_t mf);
        logic [31:0] v;
        v = rf_val;
        if (r != 5'd0 && mf.valid_dest == r) v = mf.data;
        return v;
    endfunction

    assign rf_raddr1 = e_op.rj;
    assign rf_raddr2 = e_op.rd;
    assign src1      = pick(e_op.rj, rf_rdata1, m_fwd);
    assign src2      = pick(e_op.rd, rf_rdata2, m_fwd);

    assign is_mem   = is_load(e_op.op) || is_store(e_op.op);
    assign imm_ext  = {{16{e_op.imm[15]}}, e_op.imm};
    assign vaddr    = src1 + imm_ext;
    assign need_req = is_mem && !misalign;

    always_comb begin
        case (e_op.op)
            op_ld_h, op_ld_hu, op_st_h: misalign = vaddr[0];
            op_ld_w, op_st_w:           misalign = |vaddr[1:0];
            default:                    misalign = 1'b0;
        endcase
    end

    // Load in memory stage still waiting for its data
    assign raw_stall = e_valid && !m_fwd.data_ok && m_fwd.valid_dest != 5'd0 &&
                       ((is_mem && m_fwd.valid_dest == e_op.rj) ||
                        (is_store(e_op.op) && m_fwd.valid_dest == e_op.rd));
    assign exc_stall = m_fwd.ex || w_fwd.ex;

    assign e_ready_go  = !raw_stall && !exc_stall && (!need_req || data_addr_ok);
    assign e_allowin   = !e_valid || (e_ready_go && m_allowin);
    assign issue_ready = e_allowin && !flush;
    assign em_valid    = e_valid && e_ready_go && !flush;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            e_valid <= 1'b0;
        end else if (flush) begin
            e_valid <= 1'b0;
        end else if (e_allowin) begin
            e_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid && issue_ready) begin
            e_op <= issue;
        end
    end

    // Request goes out in the same cycle the op moves on
    assign data_req  = e_valid && need_req && !raw_stall && !exc_stall && m_allowin && !flush;
    assign data_wr   = is_store(e_op.op);
    assign data_addr = vaddr;

    always_comb begin
        data_wstrb = 4'b0000;
        data_wdata = src2;
        case (e_op.op)
            op_st_b: begin
                data_wstrb = 4'b0001 << vaddr[1:0];
                data_wdata = {4{src2[7:0]}};
            end
            op_st_h: begin
                data_wstrb = vaddr[1] ? 4'b1100 : 4'b0011;
                data_wdata = {2{src2[15:0]}};
            end
            op_st_w: begin
                data_wstrb = 4'b1111;
            end
            default: ;
        endcase
    end

    always_comb begin
        em.pc       = e_op.pc;
        em.op       = e_op.op;
        em.gr_we    = !is_store(e_op.op);
        em.dest     = e_op.rd;
        em.vaddr    = vaddr;
        em.rf_wdata = imm_ext;
        em.ex       = misalign;
        if (misalign) begin
            em.ecode = ec_ale;
        end else begin
            em.ecode = ec_none;
        end
    end

endmodule

`default_nettype wire

//--- design/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  wire                clk,
    input  wire                rstn,
    input  wire                flush,
    input  wire                em_valid,
    input  wire lsu_pkg::em_t  em,
    output logic               m_allowin,
    input  wire                data_data_ok,
    input  wire [31:0]         data_rdata,
    input  wire                w_allowin,
    output logic               mw_valid,
    output lsu_pkg::mw_t       mw,
    output lsu_pkg::fwd_t      m_fwd
);
    import lsu_pkg::*;

    logic        m_valid;
    em_t         m_em;
    logic        m_load;
    logic        m_ready_go;
    logic        m_hold_ok;
    logic [31:0] m_hold_data;
    logic [31:0] raw;
    logic [31:0] shifted;
    logic [31:0] ld_result;
    logic [31:0] final_result;

    assign m_load     = m_valid && is_load(m_em.op) && !m_em.ex;
    assign m_ready_go = !m_load || m_hold_ok || data_data_ok;
    assign m_allowin  = !m_valid || (m_ready_go && w_allowin);
    assign mw_valid   = m_valid && m_ready_go;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            m_valid <= 1'b0;
        end else if (flush) begin
            m_valid <= 1'b0;
        end else if (m_allowin) begin
            m_valid <= em_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (em_valid && m_allowin) begin
            m_em <= em;
        end
    end

    // Keeps the one-cycle read data if writeback is not taking the op
    always_ff @(posedge clk) begin
        if (!rstn) begin
            m_hold_ok <= 1'b0;
        end else if (flush || m_allowin) begin
            m_hold_ok <= 1'b0;
        end else if (data_data_ok) begin
            m_hold_ok <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (data_data_ok && !m_hold_ok) begin
            m_hold_data <= data_rdata;
        end
    end

    assign raw     = m_hold_ok ? m_hold_data : data_rdata;
    assign shifted = raw >> {m_em.vaddr[1:0], 3'b000};

    always_comb begin
        case (m_em.op)
            op_ld_b:  ld_result = {{24{shifted[7]}}, shifted[7:0]};
            op_ld_bu: ld_result = {24'd0, shifted[7:0]};
            op_ld_h:  ld_result = {{16{shifted[15]}}, shifted[15:0]};
            op_ld_hu: ld_result = {16'd0, shifted[15:0]};
            default:  ld_result = shifted;
        endcase
    end

    assign final_result = m_load ? ld_result : m_em.rf_wdata;

    always_comb begin
        mw.pc    = m_em.pc;
        mw.gr_we = m_em.gr_we;
        mw.dest  = m_em.dest;
        mw.wdata = final_result;
        mw.vaddr = m_em.vaddr;
        mw.ex    = m_em.ex;
        mw.ecode = m_em.ecode;
    end

    always_comb begin
        m_fwd.valid_dest = (m_valid && m_em.gr_we && !m_em.ex) ? m_em.dest : 5'd0;
        m_fwd.data       = final_result;
        m_fwd.data_ok    = m_ready_go;
        m_fwd.ex         = m_valid && m_em.ex;
    end

endmodule

`default_nettype wire

//--- design/wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module wb_stage (
    input  wire               clk,
    input  wire               rstn,
    input  wire               mw_valid,
    input  wire lsu_pkg::mw_t mw,
    output logic              w_allowin,
    output logic              rf_we,
    output logic [4:0]        rf_waddr,
    output logic [31:0]       rf_wdata,
    output lsu_pkg::fwd_t     w_fwd,
    output logic              retire_valid,
    output lsu_pkg::retire_t  retire,
    output logic              flush
);
    import lsu_pkg::*;

    logic w_valid;
    mw_t  w_mw;

    assign w_allowin = 1'b1; // Never stalls

    always_ff @(posedge clk) begin
        if (!rstn) begin
            w_valid <= 1'b0;
        end else begin
            w_valid <= mw_valid && !flush;
        end
    end

    always_ff @(posedge clk) begin
        if (mw_valid) begin
            w_mw <= mw;
        end
    end

    assign flush    = w_valid && w_mw.ex;
    assign rf_we    = w_valid && w_mw.gr_we && !w_mw.ex;
    assign rf_waddr = w_mw.dest;
    assign rf_wdata = w_mw.wdata;

    always_comb begin
        w_fwd.valid_dest = rf_we ? w_mw.dest : 5'd0;
        w_fwd.data       = w_mw.wdata;
        w_fwd.data_ok    = 1'b1;
        w_fwd.ex         = flush;
    end

    assign retire_valid = w_valid;

    always_comb begin
        retire.pc    = w_mw.pc;
        retire.gr_we = w_mw.gr_we && !w_mw.ex;
        retire.dest  = w_mw.dest;
        retire.wdata = w_mw.wdata;
        retire.ex    = w_mw.ex;
        retire.ecode = w_mw.ecode;
    end

endmodule

`default_nettype wire

//--- design/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top #(
    parameter int DATA_LATENCY = 2,
    parameter int ADDR_WORDS   = 256
) (
    input  wire                  clk,
    input  wire                  rstn,
    input  wire                  issue_valid,
    output logic                 issue_ready,
    input  wire lsu_pkg::issue_t issue,
    output logic                 retire_valid,
    output lsu_pkg::retire_t     retire
);
    import lsu_pkg::*;

    logic        flush;
    logic [4:0]  rf_raddr1;
    logic [4:0]  rf_raddr2;
    logic [31:0] rf_rdata1;
    logic [31:0] rf_rdata2;
    logic        rf_we;
    logic [4:0]  rf_waddr;
    logic [31:0] rf_wdata;
    fwd_t        m_fwd;
    fwd_t        w_fwd;
    logic        em_valid;
    em_t         em;
    logic        m_allowin;
    logic        mw_valid;
    mw_t         mw;
    logic        w_allowin;
    logic        data_req;
    logic        data_wr;
    logic [3:0]  data_wstrb;
    logic [31:0] data_addr;
    logic [31:0] data_wdata;
    logic        data_addr_ok;
    logic        data_data_ok;
    logic [31:0] data_rdata;

    ex_stage u_ex (
        .clk          (clk),
        .rstn         (rstn),
        .flush        (flush),
        .issue_valid  (issue_valid),
        .issue_ready  (issue_ready),
        .issue        (issue),
        .rf_raddr1    (rf_raddr1),
        .rf_raddr2    (rf_raddr2),
        .rf_rdata1    (rf_rdata1),
        .rf_rdata2    (rf_rdata2),
        .m_fwd        (m_fwd),
        .w_fwd        (w_fwd),
        .m_allowin    (m_allowin),
        .em_valid     (em_valid),
        .em           (em),
        .data_req     (data_req),
        .data_wr      (data_wr),
        .data_wstrb   (data_wstrb),
        .data_addr    (data_addr),
        .data_wdata   (data_wdata),
        .data_addr_ok (data_addr_ok)
    );

    mem_stage u_mem (
        .clk          (clk),
        .rstn         (rstn),
        .flush        (flush),
        .em_valid     (em_valid),
        .em           (em),
        .m_allowin    (m_allowin),
        .data_data_ok (data_data_ok),
        .data_rdata   (data_rdata),
        .w_allowin    (w_allowin),
        .mw_valid     (mw_valid),
        .mw           (mw),
        .m_fwd        (m_fwd)
    );

    wb_stage u_wb (
        .clk          (clk),
        .rstn         (rstn),
        .mw_valid     (mw_valid),
        .mw           (mw),
        .w_allowin    (w_allowin),
        .rf_we        (rf_we),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .w_fwd        (w_fwd),
        .retire_valid (retire_valid),
        .retire       (retire),
        .flush        (flush)
    );

    reg_file u_rf (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    data_sram #(
        .DATA_LATENCY (DATA_LATENCY),
        .ADDR_WORDS   (ADDR_WORDS)
    ) u_sram (
        .clk     (clk),
        .rstn    (rstn),
        .req     (data_req),
        .wr      (data_wr),
        .wstrb   (data_wstrb),
        .addr    (data_addr),
        .wdata   (data_wdata),
        .addr_ok (data_addr_ok),
        .data_ok (data_data_ok),
        .rdata   (data_rdata)
    );

endmodule

`default_nettype wire

//--- verif/lsu_ref_model.svh
logic [31:0] model_regs [32];
logic [31:0] model_mem [256];
retire_t     exp_q [$];
logic        squash; // Set from an exception op until its flush

function automatic void model_reset();
    for (int i = 0; i < 32; i++) begin
        model_regs[i] = 32'd0;
    end
    for (int i = 0; i < 256; i++) begin
        model_mem[i] = 32'd0;
    end
    exp_q.delete();
    squash = 1'b0;
endfunction

function automatic void model_step(input issue_t op);
    retire_t     exp;
    logic [31:0] imm_ext;
    logic [31:0] addr;
    logic [31:0] lane;
    logic [31:0] sdata;
    logic        bad;
    if (squash) begin
        return; // Flushed before it reaches writeback
    end
    imm_ext = {{16{op.imm[15]}}, op.imm};
    addr    = model_regs[op.rj] + imm_ext;
    lane    = model_mem[addr[9:2]] >> {addr[1:0], 3'b000};
    sdata   = model_regs[op.rd];
    case (op.op)
        op_ld_h, op_ld_hu, op_st_h: bad = addr[0];
        op_ld_w, op_st_w:           bad = addr[1] | addr[0];
        default:                    bad = 1'b0;
    endcase
    exp       = '0;
    exp.pc    = op.pc;
    exp.dest  = op.rd;
    exp.ecode = ec_none;
    if (bad) begin
        exp.ex    = 1'b1;
        exp.ecode = ec_ale;
        squash    = 1'b1;
    end else begin
        exp.gr_we = !(op.op inside {op_st_b, op_st_h, op_st_w});
        case (op.op)
            op_li:    exp.wdata = imm_ext;
            op_ld_b:  exp.wdata = {{24{lane[7]}}, lane[7:0]};
            op_ld_bu: exp.wdata = {24'd0, lane[7:0]};
            op_ld_h:  exp.wdata = {{16{lane[15]}}, lane[15:0]};
            op_ld_hu: exp.wdata = {16'd0, lane[15:0]};
            op_ld_w:  exp.wdata = lane;
            op_st_b:  model_mem[addr[9:2]][{addr[1:0], 3'b000} +: 8] = sdata[7:0];
            op_st_h:  model_mem[addr[9:2]][{addr[1], 4'b0000} +: 16] = sdata[15:0];
            op_st_w:  model_mem[addr[9:2]] = sdata;
            default: ;
        endcase
        if (exp.gr_we && op.rd != 5'd0) begin
            model_regs[op.rd] = exp.wdata;
        end
    end
    exp_q.push_back(exp);
endfunction

//--- verif/lsu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_tb;
    import lsu_pkg::*;

    localparam int ISSUE_LIMIT = 200;
    localparam int DRAIN_LIMIT = 2000;
    localparam int RUN_LIMIT   = 50000;

    logic        clk;
    logic        rstn;
    logic        issue_valid;
    logic        issue_ready;
    issue_t      issue;
    logic        retire_valid;
    retire_t     retire;
    int          seed;
    int          n_errors  = 0;
    int          n_retired = 0;
    logic [31:0] next_pc;
    logic        all_done  = 1'b0;
    logic        hung      = 1'b0;

    `include "lsu_ref_model.svh"

    lsu_top #(
        .DATA_LATENCY (3),
        .ADDR_WORDS   (256)
    ) uut (
        .clk          (clk),
        .rstn         (rstn),
        .issue_valid  (issue_valid),
        .issue_ready  (issue_ready),
        .issue        (issue),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic value_error(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        n_errors++;
        $display("error at %0t ns: %s is %h, expected %h", $time, name, got, want);
    endtask

    task automatic stall_out(input string what);
        n_errors++;
        $display("timeout: %s", what);
        hung = 1'b1;
        forever @(posedge clk); // Parked until the watchdog ends the run
    endtask

    task automatic check_retire();
        retire_t exp;
        n_retired++;
        assert (exp_q.size() != 0) else begin
            n_errors++;
            $display("op with pc %h retired while no retire was expected", retire.pc);
        end
        if (exp_q.size() != 0) begin
            exp = exp_q.pop_front();
            assert (retire.pc == exp.pc) else value_error("retire.pc", retire.pc, exp.pc);
            assert (retire.ex == exp.ex) else
                value_error("retire.ex", 32'(retire.ex), 32'(exp.ex));
            assert (retire.ecode == exp.ecode) else
                value_error("retire.ecode", 32'(retire.ecode), 32'(exp.ecode));
            assert (retire.gr_we == exp.gr_we) else
                value_error("retire.gr_we", 32'(retire.gr_we), 32'(exp.gr_we));
            if (exp.gr_we) begin
                assert (retire.dest == exp.dest) else
                    value_error("retire.dest", 32'(retire.dest), 32'(exp.dest));
                assert (retire.wdata == exp.wdata) else
                    value_error("retire.wdata", retire.wdata, exp.wdata);
            end
            if (exp.ex) begin
                squash = 1'b0; // Younger ops went with the flush
            end
        end
    endtask

    // Mid-cycle sampling of retires and accepted ops
    always @(negedge clk) begin
        if (rstn) begin
            if (retire_valid) begin
                check_retire();
            end
            if (issue_valid && issue_ready) begin
                model_step(issue);
            end
        end
    end

    task automatic pause(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic send_op(input lsu_op_e op, input logic [4:0] rj, input logic [4:0] rd,
                           input logic [15:0] imm);
        int waited;
        issue_valid = 1'b1;
        issue.op    = op;
        issue.rj    = rj;
        issue.rd    = rd;
        issue.imm   = imm;
        issue.pc    = next_pc;
        next_pc     = next_pc + 32'd4;
        waited      = 0;
        @(negedge clk);
        while (!issue_ready && waited < ISSUE_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!issue_ready) begin
            stall_out("issue_ready stayed low, the op was never accepted");
        end
        @(posedge clk);
        #1;
        issue_valid = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            stall_out("expected retires never arrived");
        end
        pause(1);
    endtask

    task automatic random_op();
        logic [31:0] r;
        int          sel;
        lsu_op_e     op;
        logic [15:0] imm;
        r   = $random(seed);
        sel = int'(r[7:0]) % 10;
        if (sel == 0) begin
            send_op(op_li, 5'd0, 5'(1 + r[9:8]), {6'd0, r[15:10], 2'b00}); // Small base
        end else if (sel == 1) begin
            send_op(op_li, 5'd0, 5'(5 + int'(r[11:8]) % 11), r[31:16]);
        end else begin
            op  = lsu_op_e'(4'(sel - 1));
            imm = {7'd0, r[24:16]};
            if (r[31:28] != 4'd0) begin
                if (op inside {op_ld_h, op_ld_hu, op_st_h}) begin
                    imm[0] = 1'b0;
                end
                if (op inside {op_ld_w, op_st_w}) begin
                    imm[1:0] = 2'b00;
                end
            end
            send_op(op, 5'(1 + r[9:8]), 5'(5 + int'(r[13:10]) % 11), imm);
        end
        if (r[27:26] == 2'd0) begin
            pause(1);
        end
    endtask

    initial begin : stimulus
        int i;
        issue_valid = 1'b0;
        issue       = '0;
        rstn        = 1'b0;
        seed        = 32'h6fc6_960b;
        next_pc     = 32'h1c00_0000;
        model_reset();
        repeat (3) @(posedge clk);
        #1;
        rstn = 1'b1;
        @(negedge clk);
        assert (issue_ready) else value_error("issue_ready", 32'(issue_ready), 32'd1);
        assert (!retire_valid) else value_error("retire_valid", 32'(retire_valid), 32'd0);
        pause(1);

        // Load-immediates into every register used later
        for (i = 1; i <= 4; i++) begin
            send_op(op_li, 5'd0, 5'(i), 16'(i * 64));
        end
        for (i = 5; i < 16; i++) begin
            send_op(op_li, 5'd0, 5'(i), 16'(i * 32'h1d35));
        end
        drain();

        // Word, halfword and byte stores, then every load shape
        send_op(op_li, 5'd0, 5'd20, 16'h0100);
        send_op(op_li, 5'd0, 5'd21, 16'haabb);
        send_op(op_li, 5'd0, 5'd22, 16'h7f80);
        send_op(op_li, 5'd0, 5'd23, 16'hff85);
        send_op(op_st_w, 5'd20, 5'd21, 16'd0);
        send_op(op_st_h, 5'd20, 5'd22, 16'd6);
        send_op(op_st_b, 5'd20, 5'd23, 16'd9);
        for (i = 0; i < 12; i++) begin
            send_op(op_ld_b, 5'd20, 5'd24, 16'(i));
            send_op(op_ld_bu, 5'd20, 5'd25, 16'(i));
            if (i % 2 == 0) begin
                send_op(op_ld_h, 5'd20, 5'd24, 16'(i));
                send_op(op_ld_hu, 5'd20, 5'd25, 16'(i));
            end
            if (i % 4 == 0) begin
                send_op(op_ld_w, 5'd20, 5'd24, 16'(i));
            end
        end
        drain();

        // Dependent chain through forwarding and the load interlock
        send_op(op_li, 5'd0, 5'd26, 16'h0200);
        send_op(op_st_w, 5'd0, 5'd26, 16'h01f0);
        send_op(op_li, 5'd0, 5'd27, 16'h5a5a);
        send_op(op_st_w, 5'd0, 5'd27, 16'h0200);
        send_op(op_li, 5'd0, 5'd28, 16'h01f0);
        send_op(op_ld_w, 5'd28, 5'd29, 16'd0);
        send_op(op_ld_w, 5'd29, 5'd30, 16'd0);
        send_op(op_st_w, 5'd28, 5'd30, 16'd4);
        send_op(op_ld_h, 5'd28, 5'd31, 16'd4);
        drain();

        // Misaligned accesses with younger ops right behind
        send_op(op_ld_w, 5'd1, 5'd10, 16'd2);
        send_op(op_li, 5'd0, 5'd10, 16'h1111);
        send_op(op_li, 5'd0, 5'd11, 16'h2222);
        drain();
        send_op(op_st_h, 5'd1, 5'd12, 16'd1);
        send_op(op_st_w, 5'd1, 5'd12, 16'd0);
        drain();
        send_op(op_st_w, 5'd1, 5'd10, 16'd0);
        send_op(op_ld_w, 5'd1, 5'd13, 16'd0);
        send_op(op_ld_hu, 5'd1, 5'd14, 16'd2);
        drain();

        // Random mix
        for (i = 1; i <= 4; i++) begin
            send_op(op_li, 5'd0, 5'(i), {8'd0, 6'($unsigned($random(seed))), 2'b00});
        end
        for (i = 0; i < 200; i++) begin
            random_op();
        end
        drain();
        all_done = 1'b1;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (!all_done && !hung && cycles < RUN_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (cycles >= RUN_LIMIT) begin
            n_errors++;
            $display("timeout: simulation ran past %0d cycles", RUN_LIMIT);
        end
        $display("summary: %0d ops retired, %0d errors, %0d retires still expected",
                 n_retired, n_errors, exp_q.size());
        if (n_errors == 0 && exp_q.size() == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+verif
design/lsu_pkg.sv
design/reg_file.sv
design/data_sram.sv
design/ex_stage.sv
design/mem_stage.sv
design/wb_stage.sv
design/lsu_top.sv
verif/lsu_tb.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timescale 1ns/1ps --top-module lsu_tb -f files.f -o lsu_sim &&
    ./obj_dir/lsu_sim > sim.log 2>&1 ||
    { cat sim.log 2>/dev/null; echo "FAIL: build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Done: errors found" sim.log && { echo "FAIL"; exit 1; } ||
    { grep -q "Done: no errors" sim.log && echo "PASS"; } ||
    { echo "FAIL: no summary in log"; exit 1; }
